// ==== src/cache_cfg.svh ====
// Memory subsystem configuration: backing memory depth and access latency.
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Number of 32-bit words in the backing memory. Addresses wrap at this size.
`define MEM_WORDS 2048

// Cycles from the start of a memory access to its ready pulse.
`define MEM_LATENCY 3

`endif

// ==== src/cachePkg.sv ====
// Cache package: address views and controller states for the L1 memory subsystem.
package cachePkg;

  // The same address word is read as a raw byte address and as cache fields.
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [20:0] unused;
      logic [3:0]  tag;
      logic [4:0]  index;
      logic [1:0]  offset;
    } fields;
  } cacheAddr_u;

  typedef enum logic [1:0] {
    idle,
    read,  // Waiting for one or two memory read pulses.
    write, // Waiting for the write-through to complete.
    ready
  } cacheState_e;

endpackage

// ==== src/loadAligner.sv ====
// Load aligner: extracts a byte, halfword or word from a two-word window and extends it.
`timescale 1ns/1ps

module loadAligner (
  input  logic [1:0]  byteOffset,
  input  logic        byteRead,
  input  logic        halfRead,
  input  logic        unsignedRead,
  input  logic [31:0] lowWord,
  input  logic [31:0] highWord,
  output logic [31:0] dataOut
);
  logic [63:0] window;
  logic [31:0] shifted;
  logic        byteSign;
  logic        halfSign;

  // Little-endian, so the following word sits above the addressed one.
  assign window = {highWord, lowWord};
  assign shifted = window[{byteOffset, 3'b000} +: 32];

  assign byteSign = shifted[7] & ~unsignedRead;
  assign halfSign = shifted[15] & ~unsignedRead;

  always_comb begin
    if (byteRead) begin
      dataOut = {{24{byteSign}}, shifted[7:0]};
    end else if (halfRead) begin
      dataOut = {{16{halfSign}}, shifted[15:0]};
    end else begin
      dataOut = shifted; // A full word needs no extension.
    end
  end

endmodule

// ==== src/cacheArray.sv ====
// Cache array: tag, valid and data storage for 32 one-word lines with a two-line read window.
`timescale 1ns/1ps

module cacheArray (
  input  logic                clk,
  input  logic                reset,
  input  cachePkg::cacheAddr_u lookupAddress,
  input  logic                fillEnable,
  input  cachePkg::cacheAddr_u fillAddress,
  input  logic [31:0]         fillData,
  input  logic                invalidateEnable,
  input  cachePkg::cacheAddr_u windowAddress,
  output logic                hit,
  output logic [31:0]         lowWord,
  output logic [31:0]         highWord
);
  logic [31:0] lineData [32];
  logic [3:0]  lineTag [32];
  logic [31:0] lineValid;
  logic        tagMatch;
  logic [4:0]  nextIndex;

  assign tagMatch = lineTag[lookupAddress.fields.index] == lookupAddress.fields.tag;
  assign hit = lineValid[lookupAddress.fields.index] & tagMatch;

  always_ff @(posedge clk) begin
    if (reset) begin
      lineValid <= '0;
    end else begin
      if (fillEnable) begin
        lineValid[fillAddress.fields.index] <= 1'b1;
      end
      // A write only drops the line when it holds the written address.
      if (invalidateEnable && tagMatch) begin
        lineValid[lookupAddress.fields.index] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fillEnable) begin
      lineData[fillAddress.fields.index] <= fillData;
      lineTag[fillAddress.fields.index] <= fillAddress.fields.tag;
    end
  end

  // Line 31 is followed by line 0, which is where address plus 4 lands.
  assign nextIndex = windowAddress.fields.index + 5'd1;

  assign lowWord = lineData[windowAddress.fields.index];
  assign highWord = lineData[nextIndex];

endmodule

// ==== src/cacheController.sv ====
// Cache controller: FSM for load misses, two-word fetches and write-through requests.
`timescale 1ns/1ps

module cacheController (
  input  logic                 clk,
  input  logic                 reset,
  input  cachePkg::cacheAddr_u address,
  input  logic                 readEnable,
  input  logic                 writeEnable,
  input  logic                 needNextAddress,
  input  logic                 hit,
  input  logic                 memoryReady,
  output cachePkg::cacheAddr_u readAddress,
  output logic                 fillEnable,
  output logic                 invalidateEnable,
  output logic                 stateReady
);
  cachePkg::cacheState_e state;
  logic                  secondWord;
  logic                  alignedHit;

  assign alignedHit = hit & ~needNextAddress;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cachePkg::idle;
      secondWord <= 1'b0;
    end else begin
      case (state)
        cachePkg::idle: begin
          if (readEnable && !alignedHit) begin
            state <= cachePkg::read;
          end else if (writeEnable) begin
            state <= cachePkg::write;
          end
        end
        cachePkg::read: begin
          if (memoryReady) begin
            if (needNextAddress && !secondWord) begin
              secondWord <= 1'b1; // Stay here and fetch the following word.
            end else begin
              secondWord <= 1'b0;
              state <= cachePkg::ready;
            end
          end
        end
        cachePkg::write: begin
          if (memoryReady) begin
            state <= cachePkg::ready;
          end
        end
        cachePkg::ready: begin
          state <= cachePkg::idle;
        end
      endcase
    end
  end

  assign readAddress.raw = secondWord ? address.raw + 32'd4 : address.raw;

  // Every read pulse fills the line of the word being fetched.
  assign fillEnable = (state == cachePkg::read) && memoryReady;
  assign invalidateEnable = (state == cachePkg::write) && memoryReady;
  assign stateReady = state == cachePkg::ready;

endmodule

// ==== src/cacheL1.sv ====
// L1 cache: direct-mapped write-through cache between the load/store port and memory.
`timescale 1ns/1ps

module cacheL1 (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] address,
  input  logic        readEnable,
  input  logic        writeEnable,
  input  logic        byteRead,
  input  logic        halfRead,
  input  logic        unsignedRead,
  input  logic [31:0] dataIn,
  output logic [31:0] dataOut,
  output logic        cacheReady,
  output logic [31:0] memoryAddress,
  output logic [31:0] memoryDataOut,
  output logic        memoryReadEnable,
  output logic        memoryWriteEnable,
  input  logic [31:0] memoryDataIn,
  input  logic        memoryReady
);
  cachePkg::cacheAddr_u requestAddress;
  cachePkg::cacheAddr_u readAddress;
  logic                 wordRead;
  logic                 needNextAddress;
  logic                 hit;
  logic                 fillEnable;
  logic                 invalidateEnable;
  logic                 stateReady;
  logic [31:0]          lowWord;
  logic [31:0]          highWord;

  assign requestAddress.raw = address;
  assign wordRead = ~(byteRead | halfRead);

  // Loads that spill past the end of the addressed word.
  assign needNextAddress = (wordRead && requestAddress.fields.offset != 2'b00) ||
                           (halfRead && requestAddress.fields.offset == 2'b11);

  assign memoryAddress = readAddress.raw; // Equals the request address outside the second fetch.
  assign memoryDataOut = dataIn;
  assign memoryReadEnable = readEnable;
  assign memoryWriteEnable = writeEnable;

  assign cacheReady = stateReady | (readEnable & hit & ~needNextAddress) |
                      ~(readEnable | writeEnable);

  cacheController controller (
    .clk              (clk),
    .reset            (reset),
    .address          (requestAddress),
    .readEnable       (readEnable),
    .writeEnable      (writeEnable),
    .needNextAddress  (needNextAddress),
    .hit              (hit),
    .memoryReady      (memoryReady),
    .readAddress      (readAddress),
    .fillEnable       (fillEnable),
    .invalidateEnable (invalidateEnable),
    .stateReady       (stateReady)
  );

  cacheArray array (
    .clk              (clk),
    .reset            (reset),
    .lookupAddress    (requestAddress),
    .fillEnable       (fillEnable),
    .fillAddress      (readAddress),
    .fillData         (memoryDataIn),
    .invalidateEnable (invalidateEnable),
    .windowAddress    (requestAddress),
    .hit              (hit),
    .lowWord          (lowWord),
    .highWord         (highWord)
  );

  loadAligner aligner (
    .byteOffset   (requestAddress.fields.offset),
    .byteRead     (byteRead),
    .halfRead     (halfRead),
    .unsignedRead (unsignedRead),
    .lowWord      (lowWord),
    .highWord     (highWord),
    .dataOut      (dataOut)
  );

endmodule

// ==== src/mainMemory.sv ====
// Main memory: word-wide backing store that answers each access after a fixed latency.
`timescale 1ns/1ps
`include "cache_cfg.svh"

module mainMemory (
  input  logic                 clk,
  input  logic                 reset,
  input  cachePkg::cacheAddr_u memoryAddress,
  input  logic [31:0]          memoryDataIn,
  input  logic                 memoryReadEnable,
  input  logic                 memoryWriteEnable,
  output logic [31:0]          memoryDataOut,
  output logic                 memoryReady
);
  localparam int WordBits = $clog2(`MEM_WORDS);
  localparam int CountWidth = $clog2(`MEM_LATENCY + 1);

  logic [31:0]           storage [`MEM_WORDS];
  logic [WordBits-1:0]   wordIndex;
  logic [CountWidth-1:0] latencyCount;
  logic                  accessEnable;

  assign wordIndex = WordBits'((memoryAddress.raw >> 2) % `MEM_WORDS);
  assign accessEnable = memoryReadEnable | memoryWriteEnable;

  // The count keeps running through a pulse, so a held enable gets a pulse every
  // MEM_LATENCY cycles.
  always_ff @(posedge clk) begin
    if (reset) begin
      latencyCount <= '0;
      memoryReady <= 1'b0;
    end else if (!accessEnable) begin
      latencyCount <= '0;
      memoryReady <= 1'b0;
    end else if (latencyCount == CountWidth'(`MEM_LATENCY - 1)) begin
      latencyCount <= '0;
      memoryReady <= 1'b1;
    end else begin
      latencyCount <= latencyCount + 1'b1;
      memoryReady <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (memoryReady && memoryWriteEnable) begin
      storage[wordIndex] <= memoryDataIn; // Commits at the edge that ends the pulse.
    end
  end

  // Read data follows the current address, so a switched address is seen at once.
  assign memoryDataOut = storage[wordIndex];

endmodule

// ==== src/memorySubsystem.sv ====
// Memory subsystem: L1 cache in front of the fixed-latency backing memory.
`timescale 1ns/1ps

module memorySubsystem (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] address,
  input  logic        readEnable,
  input  logic        writeEnable,
  input  logic        byteRead,
  input  logic        halfRead,
  input  logic        unsignedRead,
  input  logic [31:0] dataIn,
  output logic [31:0] dataOut,
  output logic        cacheReady
);
  logic [31:0] memoryAddress;
  logic [31:0] writeData;
  logic [31:0] readData;
  logic        memoryReadEnable;
  logic        memoryWriteEnable;
  logic        memoryReady;

  cacheL1 cache (
    .clk               (clk),
    .reset             (reset),
    .address           (address),
    .readEnable        (readEnable),
    .writeEnable       (writeEnable),
    .byteRead          (byteRead),
    .halfRead          (halfRead),
    .unsignedRead      (unsignedRead),
    .dataIn            (dataIn),
    .dataOut           (dataOut),
    .cacheReady        (cacheReady),
    .memoryAddress     (memoryAddress),
    .memoryDataOut     (writeData),
    .memoryReadEnable  (memoryReadEnable),
    .memoryWriteEnable (memoryWriteEnable),
    .memoryDataIn      (readData),
    .memoryReady       (memoryReady)
  );

  mainMemory memory (
    .clk               (clk),
    .reset             (reset),
    .memoryAddress     (memoryAddress),
    .memoryDataIn      (writeData),
    .memoryReadEnable  (memoryReadEnable),
    .memoryWriteEnable (memoryWriteEnable),
    .memoryDataOut     (readData),
    .memoryReady       (memoryReady)
  );

endmodule

// ==== dv/tbMemorySubsystem.sv ====
// Memory subsystem testbench: table-driven and random loads and stores against a reference memory.
`timescale 1ns/1ps
`include "cache_cfg.svh"

module tbMemorySubsystem;
  localparam logic       OpRead = 1'b0;
  localparam logic       OpWrite = 1'b1;
  localparam logic [1:0] SizeByte = 2'd0;
  localparam logic [1:0] SizeHalf = 2'd1;
  localparam logic [1:0] SizeWord = 2'd2;
  localparam int WordBits = $clog2(`MEM_WORDS);
  localparam int ReadyTimeout = 4 * `MEM_LATENCY + 20;
  localparam int RandomWords = 128; // Random traffic covers tags 0 to 3 over all lines.
  localparam int RandomOps = 200;

  typedef struct packed {
    logic        isWrite;
    logic [31:0] addr;
    logic [1:0]  size;
    logic        isUnsigned;
    logic [31:0] writeData;
    logic [31:0] expected;
    logic        expectHit;
  } stimRow_t;

  logic        clk;
  logic        reset;
  logic [31:0] address;
  logic        readEnable;
  logic        writeEnable;
  logic        byteRead;
  logic        halfRead;
  logic        unsignedRead;
  logic [31:0] dataIn;
  logic [31:0] dataOut;
  logic        cacheReady;
  logic [31:0] refMem [`MEM_WORDS];
  stimRow_t    stimulus [$];

  memorySubsystem dut (
    .clk          (clk),
    .reset        (reset),
    .address      (address),
    .readEnable   (readEnable),
    .writeEnable  (writeEnable),
    .byteRead     (byteRead),
    .halfRead     (halfRead),
    .unsignedRead (unsignedRead),
    .dataIn       (dataIn),
    .dataOut      (dataOut),
    .cacheReady   (cacheReady)
  );

  always #50 clk = ~clk;

  task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s: got %h, expected %h", $time, what, actual, expected);
      $display("TB FAILED");
      $fatal(1, "Stopping at the first mismatch.");
    end
  endtask

  function automatic logic [WordBits-1:0] refIndex(input logic [31:0] byteAddr);
    return WordBits'((byteAddr >> 2) % `MEM_WORDS); // Memory wraps at its size.
  endfunction

  function automatic int sizeBytes(input logic [1:0] size);
    return (size == SizeByte) ? 1 : (size == SizeHalf) ? 2 : 4;
  endfunction

  // Builds the load result byte by byte from the reference memory, then extends it.
  function automatic logic [31:0] expectedLoad(input logic [31:0] addr, input logic [1:0] size,
                                               input logic isUnsigned);
    logic [31:0] value;
    logic [31:0] word;
    logic [31:0] byteAddr;
    logic        signBit;
    int          nBytes;
    int          i;
    value = '0;
    nBytes = sizeBytes(size);
    for (i = 0; i < nBytes; i++) begin
      byteAddr = addr + 32'(i);
      word = refMem[refIndex(byteAddr)];
      value[i*8 +: 8] = word[{byteAddr[1:0], 3'b000} +: 8];
    end
    signBit = value[nBytes*8-1] & ~isUnsigned;
    for (i = nBytes; i < 4; i++) begin
      value[i*8 +: 8] = {8{signBit}};
    end
    return value;
  endfunction

  function automatic int expectedCycles(input stimRow_t row);
    if (row.expectHit) begin
      return 0;
    end
    if (!row.isWrite && (int'(row.addr[1:0]) + sizeBytes(row.size)) > 4) begin
      return 2 * `MEM_LATENCY + 1; // Two fetches back to back.
    end
    return `MEM_LATENCY + 1;
  endfunction

  function automatic logic [31:0] fillPattern(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'ha5c3_0f96;
  endfunction

  function void addRow(input logic isWrite, input logic [31:0] addr, input logic [1:0] size,
                       input logic isUnsigned, input logic [31:0] writeData,
                       input logic [31:0] expected, input logic expectHit);
    stimRow_t row;
    row.isWrite = isWrite;
    row.addr = addr;
    row.size = size;
    row.isUnsigned = isUnsigned;
    row.writeData = writeData;
    row.expected = expected;
    row.expectHit = expectHit;
    stimulus.push_back(row);
  endfunction

  // Holds one request until cacheReady, samples at the falling edge and drops the enables.
  task automatic runRequest(input logic isWrite, input logic [31:0] addr, input logic [1:0] size,
                            input logic isUnsigned, input logic [31:0] writeData,
                            output int cycles, output logic [31:0] loadValue);
    int   waited;
    logic seen;
    @(posedge clk);
    address <= addr;
    readEnable <= !isWrite;
    writeEnable <= isWrite;
    byteRead <= (size == SizeByte);
    halfRead <= (size == SizeHalf);
    unsignedRead <= isUnsigned;
    dataIn <= writeData;
    seen = 1'b0;
    waited = 0;
    while (!seen && waited < ReadyTimeout) begin
      @(negedge clk);
      if (cacheReady) seen = 1'b1;
      else waited++;
    end
    if (!seen) begin
      $display("Timeout: cacheReady stayed low for %0d cycles at address %h.", waited, addr);
      $display("TB FAILED");
      $fatal(1, "Request never completed.");
    end
    cycles = waited;
    loadValue = dataOut;
    @(posedge clk);
    readEnable <= 1'b0;
    writeEnable <= 1'b0;
    if (isWrite) refMem[refIndex(addr)] = writeData;
  endtask

  function void buildTable();
    addRow(OpWrite, 32'h100, SizeWord, 1'b0, 32'hc3a2_7f81, 32'h0, 1'b0);
    addRow(OpWrite, 32'h104, SizeWord, 1'b0, 32'h1e5d_94b6, 32'h0, 1'b0);
    addRow(OpRead, 32'h100, SizeWord, 1'b0, 32'h0, 32'hc3a2_7f81, 1'b0);
    addRow(OpRead, 32'h100, SizeWord, 1'b0, 32'h0, 32'hc3a2_7f81, 1'b1);
    addRow(OpRead, 32'h100, SizeByte, 1'b0, 32'h0, 32'hffff_ff81, 1'b1);
    addRow(OpRead, 32'h100, SizeByte, 1'b1, 32'h0, 32'h0000_0081, 1'b1);
    addRow(OpRead, 32'h101, SizeByte, 1'b0, 32'h0, 32'h0000_007f, 1'b1);
    addRow(OpRead, 32'h101, SizeByte, 1'b1, 32'h0, 32'h0000_007f, 1'b1);
    addRow(OpRead, 32'h102, SizeByte, 1'b0, 32'h0, 32'hffff_ffa2, 1'b1);
    addRow(OpRead, 32'h102, SizeByte, 1'b1, 32'h0, 32'h0000_00a2, 1'b1);
    addRow(OpRead, 32'h103, SizeByte, 1'b0, 32'h0, 32'hffff_ffc3, 1'b1);
    addRow(OpRead, 32'h103, SizeByte, 1'b1, 32'h0, 32'h0000_00c3, 1'b1);
    addRow(OpRead, 32'h100, SizeHalf, 1'b0, 32'h0, 32'h0000_7f81, 1'b1);
    addRow(OpRead, 32'h100, SizeHalf, 1'b1, 32'h0, 32'h0000_7f81, 1'b1);
    addRow(OpRead, 32'h101, SizeHalf, 1'b0, 32'h0, 32'hffff_a27f, 1'b1);
    addRow(OpRead, 32'h101, SizeHalf, 1'b1, 32'h0, 32'h0000_a27f, 1'b1);
    addRow(OpRead, 32'h102, SizeHalf, 1'b0, 32'h0, 32'hffff_c3a2, 1'b1);
    addRow(OpRead, 32'h102, SizeHalf, 1'b1, 32'h0, 32'h0000_c3a2, 1'b1);
    // Loads that spill into the word at 0x104.
    addRow(OpRead, 32'h101, SizeWord, 1'b0, 32'h0, 32'hb6c3_a27f, 1'b0);
    addRow(OpRead, 32'h102, SizeWord, 1'b0, 32'h0, 32'h94b6_c3a2, 1'b0);
    addRow(OpRead, 32'h103, SizeWord, 1'b0, 32'h0, 32'h5d94_b6c3, 1'b0);
    addRow(OpRead, 32'h103, SizeHalf, 1'b0, 32'h0, 32'hffff_b6c3, 1'b0);
    addRow(OpRead, 32'h103, SizeHalf, 1'b1, 32'h0, 32'h0000_b6c3, 1'b0);
    addRow(OpWrite, 32'h100, SizeWord, 1'b0, 32'h2468_ace0, 32'h0, 1'b0);
    addRow(OpRead, 32'h100, SizeWord, 1'b0, 32'h0, 32'h2468_ace0, 1'b0);
    addRow(OpRead, 32'h100, SizeWord, 1'b0, 32'h0, 32'h2468_ace0, 1'b1);
    // 0x100 and 0x200 share line 0 with tags 2 and 4.
    addRow(OpWrite, 32'h200, SizeWord, 1'b0, 32'h5a5a_1234, 32'h0, 1'b0);
    addRow(OpRead, 32'h100, SizeWord, 1'b0, 32'h0, 32'h2468_ace0, 1'b1);
    addRow(OpRead, 32'h200, SizeWord, 1'b0, 32'h0, 32'h5a5a_1234, 1'b0);
    addRow(OpRead, 32'h100, SizeWord, 1'b0, 32'h0, 32'h2468_ace0, 1'b0);
    addRow(OpRead, 32'h200, SizeWord, 1'b0, 32'h0, 32'h5a5a_1234, 1'b0);
    addRow(OpRead, 32'h100, SizeWord, 1'b0, 32'h0, 32'h2468_ace0, 1'b0);
    addRow(OpWrite, 32'h17c, SizeWord, 1'b0, 32'h8844_2211, 32'h0, 1'b0);
    addRow(OpWrite, 32'h180, SizeWord, 1'b0, 32'h7766_5533, 32'h0, 1'b0);
    addRow(OpRead, 32'h17e, SizeWord, 1'b0, 32'h0, 32'h5533_8844, 1'b0); // Line 31 into line 0.
    addRow(OpRead, 32'h17c, SizeWord, 1'b0, 32'h0, 32'h8844_2211, 1'b1);
  endfunction

  initial begin
    int          i;
    int          cycles;
    logic [31:0] loadValue;
    logic [31:0] wordIdx;
    logic [31:0] addr;
    logic [31:0] writeData;
    logic [1:0]  offset;
    logic [1:0]  size;
    logic        isUnsigned;
    stimRow_t    row;
    void'($urandom(32'hdf44_51f4));
    clk = 1'b0;
    reset = 1'b1;
    address = '0;
    readEnable = 1'b0;
    writeEnable = 1'b0;
    byteRead = 1'b0;
    halfRead = 1'b0;
    unsignedRead = 1'b0;
    dataIn = '0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    buildTable();
    for (i = 0; i < stimulus.size(); i++) begin
      row = stimulus[i];
      runRequest(row.isWrite, row.addr, row.size, row.isUnsigned, row.writeData, cycles, loadValue);
      check(32'(cycles), 32'(expectedCycles(row)), $sformatf("cycles to ready, row %0d", i));
      if (!row.isWrite) begin
        check(loadValue, row.expected, $sformatf("load data, row %0d", i));
      end
    end

    // Every word that random loads can reach gets a known value first.
    for (i = 0; i < RandomWords; i++) begin
      addr = 32'(i) << 2;
      runRequest(OpWrite, addr, SizeWord, 1'b0, fillPattern(addr), cycles, loadValue);
    end

    for (i = 0; i < RandomOps; i++) begin
      wordIdx = $urandom % (RandomWords - 1); // The next word stays inside the filled range.
      if ($urandom % 2 == 0) begin
        writeData = $urandom;
        runRequest(OpWrite, wordIdx << 2, SizeWord, 1'b0, writeData, cycles, loadValue);
      end else begin
        offset = 2'($urandom % 4);
        size = 2'($urandom % 3);
        isUnsigned = 1'($urandom % 2);
        addr = {wordIdx[29:0], offset};
        runRequest(OpRead, addr, size, isUnsigned, 32'h0, cycles, loadValue);
        check(loadValue, expectedLoad(addr, size, isUnsigned),
              $sformatf("random load at %h, size %0d", addr, size));
      end
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+src
src/cachePkg.sv
src/loadAligner.sv
src/cacheArray.sv
src/cacheController.sv
src/cacheL1.sv
src/mainMemory.sv
src/memorySubsystem.sv
dv/tbMemorySubsystem.sv

// ==== run.sh ====
#!/bin/sh
# Builds the memory subsystem testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tbMemorySubsystem \
  -o simMemorySubsystem
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status."
  exit 1
fi

output=$(./obj_dir/simMemorySubsystem 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status."
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
